/* gb_loader.f */
src/gb_loader_pkg.sv
src/ioctl_classifier.sv
src/download_unpack.sv
src/backup_sequencer.sv
src/gb_loader.sv
sim/gb_loader_chk.sv
sim/gb_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the loader testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module gb_loader_tb \
	-f gb_loader.f \
	-o sim_gb_loader
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/sim_gb_loader > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
	echo "No result line in log"
	exit 1
fi
exit 0

/* sim/gb_loader_chk.sv */
// Concurrent checks bound into the loader top level.
// Covers the SD request lines, the cheat strobe width, the backup
// write enables and the highest block the sequencer may request.
`timescale 1ns/1ns

module gb_loader_chk import gb_loader_pkg::*; (
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  sd_rd,
	input logic                  sd_wr,
	input logic                  gg_strobe,
	input logic                  bk_wr,
	input logic                  bk_rtc_wr,
	input logic [SD_LBA_W-1:0]   sd_lba,
	input logic [RAM_MASK_W-1:0] ram_mask_file
);

	// Only one request direction at a time
	a_rd_wr: assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr high together");

	a_strobe: assert property (@(posedge clk_sys) disable iff (reset) gg_strobe |=> !gg_strobe)
		else $error("gg_strobe longer than one cycle");

	a_bk_wr: assert property (@(posedge clk_sys) disable iff (reset) !(bk_wr && bk_rtc_wr))
		else $error("bk_wr and bk_rtc_wr high together");

	// At most one clock block above the RAM mask
	a_lba: assert property (@(posedge clk_sys) disable iff (reset)
		sd_lba <= SD_LBA_W'(ram_mask_file) + 1)
		else $error("sd_lba above ram_mask_file+1");

endmodule

bind gb_loader gb_loader_chk chk0 (.*);

/* sim/gb_loader_tb.sv */
// Testbench for the loader top level.
// Applies a table of download, load and save tests, answers SD block
// requests with a responder model and checks results against a model
// built from the palette, cheat and block rules.
`timescale 1ns/1ns

module gb_loader_tb import gb_loader_pkg::*; ();

	localparam int T_PAL = 0, T_CHEAT = 1, T_CART = 2, T_LOAD = 3, T_SAVE = 4;
	localparam int ROWS = 7;
	localparam int WORST_BLOCKS = 4;

	typedef struct {
		int        kind;
		logic [7:0] ftype;
		int        words;
		int        mask;
		logic      rtc;
		logic      expect_load;
	} row_t;

	logic clk_sys, reset, ioctl_download, ioctl_wr, img_mounted, img_readonly;
	logic osd_status, load_req, save_req, autosave_en, cart_has_save, cram_wr;
	logic rtc_inuse, sd_ack, sd_buff_wr, gg_strobe, gg_clear, sd_rd, sd_wr;
	logic bk_wr, bk_rtc_wr, bk_loading, save_pending, save_supported;
	logic [IOCTL_ADDR_W-1:0]   ioctl_addr;
	logic [IOCTL_DATA_W-1:0]   ioctl_dout;
	logic [FT_W-1:0]           ioctl_index;
	logic [IMG_SIZE_W-1:0]     img_size;
	logic [RAM_MASK_W-1:0]     ram_mask_file;
	logic [RTC_STAMP_W-1:0]    rtc_timestamp;
	logic [RTC_SAVED_W-1:0]    rtc_savedtime;
	logic [SD_DATA_W-1:0]      bk_q, sd_buff_din;
	logic [SD_BUFF_ADDR_W-1:0] sd_buff_addr;
	logic [CHEAT_W-1:0]        gg_code;
	logic [PAL_ENTRY_W-1:0]    pal1, pal2, pal3, pal4;
	logic [SD_LBA_W-1:0]       sd_lba;
	logic [BK_ADDR_W-1:0]      bk_addr;

	row_t rows [ROWS];
	integer seed = 32'he02f2a8f;
	int errors = 0;
	int strobes = 0;
	int blocks, cnt_wr, cnt_rtc;
	logic [SD_LBA_W-1:0] lbas [16];
	logic [127:0] pal_model = PALETTE_DEFAULT;

	gb_loader dut0 (.*);

	// Backup RAM contents seen by the cartridge side
	function automatic logic [SD_DATA_W-1:0] ram_pattern(logic [BK_ADDR_W-1:0] a);
		return {a[7:0], a[15:8]} ^ {a[16], 15'h1234};
	endfunction

	assign bk_q = ram_pattern(bk_addr);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		#(ROWS * WORST_BLOCKS * 300 * 8);
		$display("Timeout: run did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	always @(posedge clk_sys)
		if (!reset && gg_strobe)
			strobes <= strobes + 1;

	task automatic compare_code(string name, logic [CHEAT_W-1:0] got, logic [CHEAT_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_pal(string name, logic [PAL_ENTRY_W-1:0] got,
		logic [PAL_ENTRY_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_word(string name, logic [SD_DATA_W-1:0] got,
		logic [SD_DATA_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_lba(string name, logic [SD_LBA_W-1:0] got, logic [SD_LBA_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_addr(string name, logic [BK_ADDR_W-1:0] got,
		logic [BK_ADDR_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////
	// SD responder
	//////////////////////////////
	initial begin
		logic is_load;
		int delay;
		forever begin
			@(negedge clk_sys);
			if (!reset && (sd_rd || sd_wr)) begin
				is_load = sd_rd;
				lbas[blocks % 16] = sd_lba;
				delay = 1 + ($unsigned($random(seed)) % 4);
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				for (int i = 0; i < 256; i++) begin
					@(negedge clk_sys);
					sd_buff_addr = SD_BUFF_ADDR_W'(i);
					sd_buff_wr = is_load;
					#1;
					cnt_wr += int'(bk_wr);
					cnt_rtc += int'(bk_rtc_wr);
					compare_addr("bk_addr", bk_addr, BK_ADDR_W'(blocks * 256 + i));
					if (!is_load && blocks > int'(ram_mask_file)) begin
						if (i < 2)
							compare_word("sd_buff_din", sd_buff_din, rtc_timestamp[16*i +: 16]);
						else if (i < 5)
							compare_word("sd_buff_din", sd_buff_din,
								rtc_savedtime[16*(i-2) +: 16]);
						else
							compare_word("sd_buff_din", sd_buff_din, RTC_FILL);
					end else if (!is_load) begin
						compare_word("sd_buff_din", sd_buff_din,
							ram_pattern(BK_ADDR_W'(blocks * 256 + i)));
					end
				end
				@(negedge clk_sys);
				sd_buff_wr = 1'b0;
				sd_ack = 1'b0;
				blocks++;
			end
		end
	end

	task automatic check_transfer(int mask, logic rtc, logic is_load);
		if (blocks != mask + 1 + int'(rtc)) begin
			errors++;
			$display("Wrong number of blocks: %0d instead of %0d", blocks,
				mask + 1 + int'(rtc));
		end
		for (int b = 0; b < blocks && b < 16; b++)
			compare_lba("sd_lba", lbas[b], b);
		compare_word("bk_wr count", SD_DATA_W'(cnt_wr),
			SD_DATA_W'(is_load ? 256 * (mask + 1) : 0));
		compare_word("bk_rtc_wr count", SD_DATA_W'(cnt_rtc),
			SD_DATA_W'((is_load && rtc) ? 256 : 0));
	endtask

	// Waits for the start of a transfer, then for the last block
	task automatic run_transfer(int mask, logic rtc, logic is_load, output logic seen);
		int limit;
		seen = 1'b0;
		for (int i = 0; i < 16 && !seen; i++) begin
			@(negedge clk_sys);
			seen = is_load ? bk_loading : sd_wr;
		end
		if (seen) begin
			limit = (mask + 2 + int'(rtc)) * 300;
			while (limit > 0 && (blocks < mask + 1 + int'(rtc) || sd_ack || bk_loading)) begin
				@(negedge clk_sys);
				limit--;
			end
			if (limit == 0) begin
				errors++;
				$display("Transfer did not finish");
			end
			check_transfer(mask, rtc, is_load);
		end
	endtask

	task automatic send_words(logic [7:0] ftype, int words, int kind);
		logic [15:0] w;
		logic [127:0] code;
		int f;
		code = gg_code;
		ioctl_index = ftype;
		ioctl_download = 1'b1;
		for (int i = 0; i < words; i++) begin
			@(negedge clk_sys);
			w = 16'($random(seed));
			ioctl_wr = 1'b1;
			ioctl_addr = IOCTL_ADDR_W'(2 * i);
			ioctl_dout = w;
			img_mounted = (kind == T_CART && i == 1);
			f = i / 2;
			if (kind == T_PAL)
				pal_model = {pal_model[111:0], w[7:0], w[15:8]};
			if (kind == T_CHEAT && i[0])
				code[127 - 32 * f -: 16] = w;
			else if (kind == T_CHEAT)
				code[111 - 32 * f -: 16] = w;
			#1 compare_flag("gg_clear", gg_clear, kind != T_CHEAT || i == 0);
		end
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		img_mounted = 1'b0;
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		if (kind == T_CHEAT)
			compare_code("gg_code", gg_code, code);
	endtask

	task automatic check_palette();
		compare_pal("pal1", pal1, pal_model[127 -: 24]);
		compare_pal("pal2", pal2, pal_model[103 -: 24]);
		compare_pal("pal3", pal3, pal_model[79 -: 24]);
		compare_pal("pal4", pal4, pal_model[55 -: 24]);
	endtask

	initial begin
		int e0, s0;
		logic seen;
		rows[0] = '{T_PAL, 8'h03, 5, 0, 1'b0, 1'b0};
		rows[1] = '{T_CHEAT, 8'hFF, 8, 0, 1'b0, 1'b0};
		rows[2] = '{T_CART, 8'h41, 4, 1, 1'b0, 1'b1};
		rows[3] = '{T_LOAD, 8'h00, 0, 2, 1'b0, 1'b1};
		rows[4] = '{T_LOAD, 8'h00, 0, 1, 1'b1, 1'b1};
		rows[5] = '{T_SAVE, 8'h00, 0, 1, 1'b1, 1'b1};
		rows[6] = '{T_CART, 8'h01, 4, 1, 1'b0, 1'b0};
		{ioctl_download, ioctl_wr, img_mounted, img_readonly, osd_status} = '0;
		{load_req, save_req, autosave_en, cram_wr, rtc_inuse, sd_ack, sd_buff_wr} = '0;
		{ioctl_addr, ioctl_dout, ioctl_index, ram_mask_file, sd_buff_addr} = '0;
		cart_has_save = 1'b1;
		img_size = 64'h8000;
		rtc_timestamp = $random(seed);
		rtc_savedtime = RTC_SAVED_W'({$random(seed), $random(seed)});
		reset = 1'b1;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		check_palette();
		for (int r = 0; r < ROWS; r++) begin
			e0 = errors;
			s0 = strobes;
			blocks = 0;
			cnt_wr = 0;
			cnt_rtc = 0;
			ram_mask_file = RAM_MASK_W'(rows[r].mask);
			rtc_inuse = rows[r].rtc;
			img_readonly = ~rows[r].expect_load;
			case (rows[r].kind)
				T_PAL: begin
					send_words(rows[r].ftype, rows[r].words, T_PAL);
					check_palette();
				end
				T_CHEAT: begin
					send_words(rows[r].ftype, rows[r].words, T_CHEAT);
					compare_word("gg_strobe count", SD_DATA_W'(strobes - s0), 16'd1);
				end
				T_CART: begin
					send_words(rows[r].ftype, rows[r].words, T_CART);
					compare_flag("save_supported", save_supported, rows[r].expect_load);
					run_transfer(rows[r].mask, rows[r].rtc, 1'b1, seen);
					compare_flag("bk_loading", seen, rows[r].expect_load);
				end
				T_LOAD: begin
					@(negedge clk_sys) load_req = 1'b1;
					@(negedge clk_sys) load_req = 1'b0;
					run_transfer(rows[r].mask, rows[r].rtc, 1'b1, seen);
					compare_flag("bk_loading", seen, 1'b1);
				end
				default: begin
					@(negedge clk_sys) cram_wr = 1'b1;
					@(negedge clk_sys) cram_wr = 1'b0;
					@(negedge clk_sys) compare_flag("save_pending", save_pending, 1'b1);
					osd_status = 1'b1;
					autosave_en = 1'b1;
					run_transfer(rows[r].mask, rows[r].rtc, 1'b0, seen);
					compare_flag("sd_wr", seen, 1'b1);
					repeat (4) @(negedge clk_sys);
					compare_flag("save_pending", save_pending, 1'b0);
					osd_status = 1'b0;
				end
			endcase
			$display("test %0d kind %0d: %s", r, rows[r].kind, errors == e0 ? "ok" : "FAIL");
		end
		$display("%0d tests run, %0d errors", ROWS, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* src/backup_sequencer.sv */
// Backup-RAM load and save sequencer on the SD block port.
// Tracks dirty battery RAM, turns load and save requests into edges,
// then walks 512-byte blocks from LBA 0 up to the RAM mask, plus one
// clock block when the cartridge has an RTC. Loads write through
// bk_wr or bk_rtc_wr, saves read bk_q or the clock words.
`timescale 1ns/1ns

module backup_sequencer import gb_loader_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      cart_done,
	input  logic                      bk_ena,
	input  logic [IMG_SIZE_W-1:0]     img_size,
	input  logic                      osd_status,
	input  logic                      load_req,
	input  logic                      save_req,
	input  logic                      autosave_en,
	input  logic                      cart_has_save,
	input  logic                      cram_wr,
	input  logic [RAM_MASK_W-1:0]     ram_mask_file,
	input  logic                      rtc_inuse,
	input  logic [RTC_STAMP_W-1:0]    rtc_timestamp,
	input  logic [RTC_SAVED_W-1:0]    rtc_savedtime,
	input  logic [SD_DATA_W-1:0]      bk_q,
	input  logic                      sd_ack,
	input  logic [SD_BUFF_ADDR_W-1:0] sd_buff_addr,
	input  logic                      sd_buff_wr,
	output logic [SD_LBA_W-1:0]       sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic [SD_DATA_W-1:0]      sd_buff_din,
	output logic [BK_ADDR_W-1:0]      bk_addr,
	output logic                      bk_wr,
	output logic                      bk_rtc_wr,
	output logic                      bk_loading,
	output logic                      save_pending,
	output logic                      save_supported
);

	bk_state_t state;

	logic bk_load;
	logic bk_save;
	logic old_load;
	logic old_save;
	logic load_edge;
	logic save_edge;
	logic old_ack;
	logic in_ram;
	logic last_blk;

	assign save_supported = cart_has_save & bk_ena;

	// Auto load rides on the one-cycle cart_done pulse
	assign bk_load = load_req | (cart_done & (|img_size));
	assign bk_save = save_req | (save_pending & osd_status & autosave_en);

	//////////////////////////////
	// Dirty flag and trigger edges
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			save_pending <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			load_edge    <= 1'b0;
			save_edge    <= 1'b0;
		end else begin
			// Game writes only count while it is running
			if (cram_wr & ~osd_status & save_supported)
				save_pending <= 1'b1;
			else if (state != BK_IDLE)
				save_pending <= 1'b0;

			old_load  <= bk_load;
			old_save  <= bk_save;
			load_edge <= bk_load & ~old_load;
			save_edge <= bk_save & ~old_save;
		end
	end

	// Blocks above the mask hold RTC data
	assign in_ram   = (sd_lba <= SD_LBA_W'(ram_mask_file));
	assign last_blk = (sd_lba >= SD_LBA_W'(ram_mask_file) + SD_LBA_W'(rtc_inuse));

	//////////////////////////////
	// Block state machine
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= BK_IDLE;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
			old_ack    <= 1'b0;
		end else begin
			old_ack <= sd_ack;
			case (state)
				BK_IDLE: begin
					// Load wins if both edges land together
					if (bk_ena & (load_edge | save_edge)) begin
						state      <= BK_XFER;
						bk_loading <= load_edge;
						sd_lba     <= '0;
						sd_rd      <= load_edge;
						sd_wr      <= ~load_edge;
					end
				end
				BK_XFER: begin
					// Host has taken the request
					if (~old_ack & sd_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_WAIT_END;
					end
				end
				BK_WAIT_END: begin
					if (old_ack & ~sd_ack) begin
						if (last_blk) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							state  <= BK_XFER;
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Buffer side
	//////////////////////////////
	assign bk_addr   = {sd_lba[BK_ADDR_W-SD_BUFF_ADDR_W-1:0], sd_buff_addr};
	assign bk_wr     = in_ram & sd_buff_wr & sd_ack;
	assign bk_rtc_wr = ~in_ram & sd_buff_wr & sd_ack;

	// Clock block uses five words, rest padded
	always_comb begin
		if (in_ram) begin
			sd_buff_din = bk_q;
		end else begin
			case (sd_buff_addr)
				8'd0:    sd_buff_din = rtc_timestamp[15:0];
				8'd1:    sd_buff_din = rtc_timestamp[31:16];
				8'd2:    sd_buff_din = rtc_savedtime[15:0];
				8'd3:    sd_buff_din = rtc_savedtime[31:16];
				8'd4:    sd_buff_din = rtc_savedtime[47:32];
				default: sd_buff_din = RTC_FILL;
			endcase
		end
	end

endmodule

/* src/download_unpack.sv */
// Word unpacker for palette and cheat downloads.
// Palette words shift into a 128-bit store whose top 96 bits are
// the four colour entries. Cheat words land in a 128-bit record and
// the last word of each record strobes it into the cheat engine.
// gg_clear wipes the engine at the start of a new load.
`timescale 1ns/1ns

module download_unpack import gb_loader_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  download_kind_t          download_kind,
	input  logic                    ioctl_wr,
	input  logic [IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [IOCTL_DATA_W-1:0] ioctl_dout,
	output logic [CHEAT_W-1:0]      gg_code,
	output logic                    gg_strobe,
	output logic                    gg_clear,
	output logic [PAL_ENTRY_W-1:0]  pal1,
	output logic [PAL_ENTRY_W-1:0]  pal2,
	output logic [PAL_ENTRY_W-1:0]  pal3,
	output logic [PAL_ENTRY_W-1:0]  pal4
);

	logic [PAL_STORE_W-1:0] palette;
	logic                   pal_wr;
	logic                   cheat_wr;

	assign pal_wr   = ioctl_wr & (download_kind == DL_PALETTE);
	assign cheat_wr = ioctl_wr & (download_kind == DL_CHEAT);

	//////////////////////////////
	// Palette
	//////////////////////////////
	// Host sends entries big endian, so swap bytes on the way in
	always_ff @(posedge clk_sys) begin
		if (reset)
			palette <= PALETTE_DEFAULT;
		else if (pal_wr)
			palette <= {palette[PAL_STORE_W-IOCTL_DATA_W-1:0], ioctl_dout[7:0], ioctl_dout[15:8]};
	end

	assign pal1 = palette[PAL_STORE_W-1 -: PAL_ENTRY_W];
	assign pal2 = palette[PAL_STORE_W-1-PAL_ENTRY_W -: PAL_ENTRY_W];
	assign pal3 = palette[PAL_STORE_W-1-2*PAL_ENTRY_W -: PAL_ENTRY_W];
	assign pal4 = palette[PAL_STORE_W-1-(PAL_ENTRIES-1)*PAL_ENTRY_W -: PAL_ENTRY_W];

	//////////////////////////////
	// Cheat record
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (ioctl_addr[3:0])
				4'd0:           gg_code[111:96]  <= ioctl_dout;
				4'd2:           gg_code[127:112] <= ioctl_dout;
				4'd4:           gg_code[79:64]   <= ioctl_dout;
				4'd6:           gg_code[95:80]   <= ioctl_dout;
				4'd8:           gg_code[47:32]   <= ioctl_dout;
				4'd10:          gg_code[63:48]   <= ioctl_dout;
				4'd12:          gg_code[15:0]    <= ioctl_dout;
				CHEAT_OFS_LAST: gg_code[31:16]   <= ioctl_dout;
				default:        ;
			endcase
		end
	end

	// Record is complete once the replace top word is in
	always_ff @(posedge clk_sys) begin
		if (reset)
			gg_strobe <= 1'b0;
		else
			gg_strobe <= cheat_wr & (ioctl_addr[3:0] == CHEAT_OFS_LAST);
	end

	// Any cart or palette load, or the first word of a cheat file
	assign gg_clear = (download_kind == DL_CART) | (download_kind == DL_PALETTE) |
		(cheat_wr & (ioctl_addr == '0));

endmodule

/* src/gb_loader.sv */
// Top level of the cartridge-support control path.
// Host download words go to the classifier and the unpacker, the
// backup sequencer talks to the SD block port and the cartridge RAM.
// The cartridge takes sd_buff_dout straight from the host.
`timescale 1ns/1ns

module gb_loader import gb_loader_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  logic [IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [IOCTL_DATA_W-1:0]   ioctl_dout,
	input  logic [FT_W-1:0]           ioctl_index,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic [IMG_SIZE_W-1:0]     img_size,
	input  logic                      osd_status,
	input  logic                      load_req,
	input  logic                      save_req,
	input  logic                      autosave_en,
	input  logic                      cart_has_save,
	input  logic                      cram_wr,
	input  logic [RAM_MASK_W-1:0]     ram_mask_file,
	input  logic                      rtc_inuse,
	input  logic [RTC_STAMP_W-1:0]    rtc_timestamp,
	input  logic [RTC_SAVED_W-1:0]    rtc_savedtime,
	input  logic [SD_DATA_W-1:0]      bk_q,
	input  logic                      sd_ack,
	input  logic [SD_BUFF_ADDR_W-1:0] sd_buff_addr,
	input  logic                      sd_buff_wr,
	output logic [CHEAT_W-1:0]        gg_code,
	output logic                      gg_strobe,
	output logic                      gg_clear,
	output logic [PAL_ENTRY_W-1:0]    pal1,
	output logic [PAL_ENTRY_W-1:0]    pal2,
	output logic [PAL_ENTRY_W-1:0]    pal3,
	output logic [PAL_ENTRY_W-1:0]    pal4,
	output logic [SD_LBA_W-1:0]       sd_lba,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic [SD_DATA_W-1:0]      sd_buff_din,
	output logic [BK_ADDR_W-1:0]      bk_addr,
	output logic                      bk_wr,
	output logic                      bk_rtc_wr,
	output logic                      bk_loading,
	output logic                      save_pending,
	output logic                      save_supported
);

	download_kind_t download_kind;
	logic           cart_done;
	logic           bk_ena;

	ioctl_classifier classifier0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.download_kind  (download_kind),
		.cart_done      (cart_done),
		.bk_ena         (bk_ena)
	);

	download_unpack unpack0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.download_kind (download_kind),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.gg_code       (gg_code),
		.gg_strobe     (gg_strobe),
		.gg_clear      (gg_clear),
		.pal1          (pal1),
		.pal2          (pal2),
		.pal3          (pal3),
		.pal4          (pal4)
	);

	backup_sequencer backup0 (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cart_done      (cart_done),
		.bk_ena         (bk_ena),
		.img_size       (img_size),
		.osd_status     (osd_status),
		.load_req       (load_req),
		.save_req       (save_req),
		.autosave_en    (autosave_en),
		.cart_has_save  (cart_has_save),
		.cram_wr        (cram_wr),
		.ram_mask_file  (ram_mask_file),
		.rtc_inuse      (rtc_inuse),
		.rtc_timestamp  (rtc_timestamp),
		.rtc_savedtime  (rtc_savedtime),
		.bk_q           (bk_q),
		.sd_ack         (sd_ack),
		.sd_buff_addr   (sd_buff_addr),
		.sd_buff_wr     (sd_buff_wr),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.sd_buff_din    (sd_buff_din),
		.bk_addr        (bk_addr),
		.bk_wr          (bk_wr),
		.bk_rtc_wr      (bk_rtc_wr),
		.bk_loading     (bk_loading),
		.save_pending   (save_pending),
		.save_supported (save_supported)
	);

endmodule

/* src/gb_loader_pkg.sv */
// Shared definitions for the cartridge-support loader.
// Holds the host file-type codes, bus widths, palette reset value
// and the enums used by the download and backup-RAM stages.
// Modules pull these in with a wildcard import in their header.

package gb_loader_pkg;

	//////////////////////////////
	// Host download port
	//////////////////////////////
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;
	localparam int FT_W         = 8;

	// File types sent by the host menu
	localparam logic [FT_W-1:0] FT_CART_GB  = 8'h01;
	localparam logic [FT_W-1:0] FT_CART_GBC = 8'h41;
	localparam logic [FT_W-1:0] FT_CART_ALT = 8'h80;
	localparam logic [FT_W-1:0] FT_PALETTE  = 8'h03;
	localparam logic [FT_W-1:0] FT_CHEAT    = 8'hFF;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_CART,
		DL_PALETTE,
		DL_CHEAT
	} download_kind_t;

	//////////////////////////////
	// Palette and cheat record
	//////////////////////////////
	localparam int PAL_ENTRY_W = 24;
	localparam int PAL_ENTRIES = 4;
	localparam int PAL_STORE_W = 128;
	// Four entries in the top 96 bits, the low word is scratch
	localparam logic [PAL_STORE_W-1:0] PALETTE_DEFAULT = 128'h828214517356305A5F1A3B4900000000;

	// Flags, address, compare, replace from the top down
	localparam int CHEAT_W = 128;
	localparam logic [3:0] CHEAT_OFS_LAST = 4'd14;

	//////////////////////////////
	// SD block port and backup RAM
	//////////////////////////////
	localparam int SD_LBA_W       = 32;
	localparam int SD_BUFF_ADDR_W = 8;
	localparam int SD_DATA_W      = 16;
	localparam int BK_ADDR_W      = 17;
	localparam int RAM_MASK_W     = 8;
	localparam int IMG_SIZE_W     = 64;

	localparam int RTC_STAMP_W = 32;
	localparam int RTC_SAVED_W = 48;
	localparam logic [SD_DATA_W-1:0] RTC_FILL = 16'hFFFF;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_XFER,
		BK_WAIT_END
	} bk_state_t;

endpackage

/* src/ioctl_classifier.sv */
// Download classifier for the host ioctl stream.
// Maps the file type of an active download to a download kind,
// pulses cart_done when a cartridge download ends and tracks
// whether a writable save image was mounted during that download.
`timescale 1ns/1ns

module ioctl_classifier import gb_loader_pkg::*; (
	input  logic            clk_sys,
	input  logic            reset,
	input  logic            ioctl_download,
	input  logic [FT_W-1:0] ioctl_index,
	input  logic            img_mounted,
	input  logic            img_readonly,
	output download_kind_t  download_kind,
	output logic            cart_done,
	output logic            bk_ena
);

	logic cart_dl;
	logic old_cart_dl;

	// Kind follows the download level with no delay
	always_comb begin
		download_kind = DL_NONE;
		if (ioctl_download) begin
			case (ioctl_index)
				FT_CART_GB,
				FT_CART_GBC,
				FT_CART_ALT: download_kind = DL_CART;
				FT_PALETTE:  download_kind = DL_PALETTE;
				FT_CHEAT:    download_kind = DL_CHEAT;
				default:     download_kind = DL_NONE;
			endcase
		end
	end

	assign cart_dl = (download_kind == DL_CART);

	//////////////////////////////
	// Cart start and end
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_cart_dl <= 1'b0;
			cart_done   <= 1'b0;
			bk_ena      <= 1'b0;
		end else begin
			old_cart_dl <= cart_dl;
			cart_done   <= old_cart_dl & ~cart_dl;

			// New cart drops any old save image
			if (~old_cart_dl & cart_dl)
				bk_ena <= 1'b0;

			// Host mounts the save file while the cart is still loading
			if (cart_dl & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;
		end
	end

endmodule
